/* ucb_cfg.svh */
// UCB configuration macros

`ifndef UCB_CFG_SVH
`define UCB_CFG_SVH

////////////////////////////////////////
// Bus widths
////////////////////////////////////////

// Inbound beat width from the IO bridge
`define UCB_IN_WIDTH 32

// Outbound beat width toward the IO bridge
`define UCB_OUT_WIDTH 8

// Widest data the local unit can return
`define UCB_REG_WIDTH 128

////////////////////////////////////////
// Local unit
////////////////////////////////////////

// Register file depth
`define UCB_NUM_REGS 8

// Register index that raises an interrupt when written
`define UCB_DOORBELL 7

// Device ID placed in interrupt headers, 9 bits
`define UCB_DEV_ID 9'd5

`endif

/* ucb_pkg.sv */
// UCB shared types

`include "ucb_cfg.svh"

package ucb_pkg;

   // Packet type field, low nibble of every header
   typedef enum logic [3:0] {
      PKT_READ_ACK  = 4'b0001,
      PKT_READ_NACK = 4'b0011,
      PKT_READ_REQ  = 4'b0100,
      PKT_WRITE_REQ = 4'b0101,
      PKT_INT       = 4'b1000
   } ucb_pkt_e;

   // Header fields
   typedef logic [4:0]  thr_t;
   typedef logic [1:0]  buf_t;
   typedef logic [2:0]  size_t;
   typedef logic [39:0] addr_t;
   typedef logic [8:0]  dev_t;
   typedef logic [3:0]  stat_t;
   typedef logic [5:0]  vec_t;
   typedef logic [63:0] dword_t;

   // Double word access, the only legal write size
   localparam size_t SIZE_DWORD = 3'b011;

   // Request and ack header, 64 bits
   typedef struct packed {
      logic [9:0] rsv;
      addr_t      addr;
      size_t      size;
      buf_t       buf_id;
      thr_t       thr;
      ucb_pkt_e   pkt;
   } ucb_hdr_t;

   // Interrupt header, 64 bits
   typedef struct packed {
      logic [35:0] rsv;
      vec_t        vec;
      stat_t       stat;
      dev_t        dev;
      thr_t        thr;
      ucb_pkt_e    pkt;
   } ucb_int_hdr_t;

   // Request toward the local unit
   typedef struct packed {
      thr_t   thr;
      buf_t   buf_id;
      size_t  size;
      addr_t  addr;
      dword_t data;
   } ucb_req_t;

   // Read reply from the local unit
   typedef struct packed {
      logic                      nack;
      logic                      data128;
      thr_t                      thr;
      buf_t                      buf_id;
      logic [`UCB_REG_WIDTH-1:0] data;
   } ucb_ack_t;

   // Interrupt from the local unit
   typedef struct packed {
      thr_t  thr;
      stat_t stat;
      vec_t  vec;
   } ucb_int_t;

endpackage

/* ucb_bus_in.sv */
// UCB inbound deserializer

`timescale 1ns/1ps

module ucb_bus_in #(
   parameter int WIDTH = 32
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             in_vld,
   input  logic [WIDTH-1:0] in_data,
   input  logic             stall_a1,
   output logic             stall,
   output logic             buf_vld,
   output logic [127:0]     in_buf
);

   localparam int BEATS = 128 / WIDTH;
   localparam int CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;

   logic [CNT_W-1:0] beat_cnt;
   logic [127:0]     asm_q;
   logic [127:0]     asm_next;
   logic             asm_full;
   logic             last_beat;
   logic             buf_free;

   ////////////////////////////////////////
   // Beat assembly
   ////////////////////////////////////////

   // Least significant beat arrives first, so shift in from the top
   assign asm_next  = {in_data, asm_q[127:WIDTH]};
   assign last_beat = in_vld && (beat_cnt == CNT_W'(BEATS - 1));

   // Held buffer can take a new packet unless the decode is stalling it
   assign buf_free  = !buf_vld || !stall_a1;

   always_ff @(posedge clk) begin
      if (rst) begin
         beat_cnt <= '0;
      end else if (in_vld) begin
         beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (in_vld) begin
         asm_q <= asm_next;
      end
   end

   // Packet finished while the held buffer was busy
   always_ff @(posedge clk) begin
      if (rst) begin
         asm_full <= 1'b0;
      end else if (last_beat && !buf_free) begin
         asm_full <= 1'b1;
      end else if (buf_free) begin
         asm_full <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // Held packet buffer
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         buf_vld <= 1'b0;
      end else if (buf_free) begin
         buf_vld <= last_beat || asm_full;
      end
   end

   always_ff @(posedge clk) begin
      if (buf_free && last_beat) begin
         in_buf <= asm_next;
      end else if (buf_free && asm_full) begin
         in_buf <= asm_q;
      end
   end

   // Stall to the sender lags the decode by one cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         stall <= 1'b0;
      end else begin
         stall <= stall_a1;
      end
   end

   // Sender honours stall before opening a packet
   a_no_start_on_stall: assert property (@(posedge clk) disable iff (rst)
      (in_vld && beat_cnt == '0) |-> !stall)
      else $error("ucb_bus_in: packet started while stall high");

endmodule

/* ucb_bus_out.sv */
// UCB outbound serializer

`timescale 1ns/1ps

`include "ucb_cfg.svh"

module ucb_bus_out #(
   parameter  int WIDTH = 8,
   localparam int BUF_W = `UCB_REG_WIDTH + 64,
   localparam int VEC_W = BUF_W / WIDTH
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             buf_wr,
   input  logic [BUF_W-1:0] buf_in,
   input  logic [VEC_W-1:0] vec_in,
   input  logic             out_stall,
   output logic             busy,
   output logic             out_vld,
   output logic [WIDTH-1:0] out_data
);

   // Outgoing packet with the lowest beat in the bottom slice
   logic [BUF_W-1:0] buf_q;

   // One bit per remaining beat from bit 0 up
   logic [VEC_W-1:0] vec_q;

   ////////////////////////////////////////
   // Shift control
   ////////////////////////////////////////

   // Busy while any beat is still to go
   assign busy = |vec_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         vec_q <= '0;
      end else if (buf_wr) begin
         vec_q <= vec_in;
      end else if (busy && !out_stall) begin
         vec_q <= vec_q >> 1;
      end
   end

   // Payload shifts with the vector
   always_ff @(posedge clk) begin
      if (buf_wr) begin
         buf_q <= buf_in;
      end else if (busy && !out_stall) begin
         buf_q <= buf_q >> WIDTH;
      end
   end

   ////////////////////////////////////////
   // Outbound bus
   ////////////////////////////////////////

   // A stalled cycle carries no beat
   assign out_vld  = vec_q[0] && !out_stall;
   assign out_data = buf_q[WIDTH-1:0];

   // Arbiter only loads an idle serializer
   a_no_wr_when_busy: assert property (@(posedge clk) disable iff (rst)
      buf_wr |-> !busy)
      else $error("ucb_bus_out: buffer written while busy");

endmodule

/* ucb_noflow.sv */
// UCB control block

`timescale 1ns/1ps

`include "ucb_cfg.svh"

module ucb_noflow (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      in_vld,
   input  logic [`UCB_IN_WIDTH-1:0]  in_data,
   output logic                      stall,
   output logic                      rd_req_vld,
   output logic                      wr_req_vld,
   output ucb_pkg::ucb_req_t         req,
   input  logic                      ack_vld,
   input  ucb_pkg::ucb_ack_t         ack,
   input  logic                      int_vld,
   input  ucb_pkg::ucb_int_t         int_req,
   output logic                      int_busy,
   output logic                      out_vld,
   output logic [`UCB_OUT_WIDTH-1:0] out_data,
   input  logic                      out_stall
);

   import ucb_pkg::*;

   localparam int OUT_W     = `UCB_OUT_WIDTH;
   localparam int BUF_W     = `UCB_REG_WIDTH + 64;
   localparam int VEC_W     = BUF_W / OUT_W;
   localparam int HDR_BEATS = 64 / OUT_W;
   localparam int D64_BEATS = 128 / OUT_W;

   // Beat masks: header only, header plus 64 bits, full buffer
   localparam logic [VEC_W-1:0] VEC_HDR  = {{(VEC_W-HDR_BEATS){1'b0}}, {HDR_BEATS{1'b1}}};
   localparam logic [VEC_W-1:0] VEC_D64  = {{(VEC_W-D64_BEATS){1'b0}}, {D64_BEATS{1'b1}}};
   localparam logic [VEC_W-1:0] VEC_D128 = '1;

   logic             in_buf_vld;
   logic [127:0]     in_buf;
   ucb_hdr_t         in_hdr;
   logic             stall_a1;
   logic             read_pending;
   logic             write_pending;
   logic             read_outstanding;
   logic             ack_buf_vld;
   logic             ack_buf_rd;
   ucb_ack_t         ack_buf_q;
   logic             int_buf_vld;
   logic             int_buf_rd;
   ucb_int_t         int_buf_q;
   logic             int_last_rd;
   logic             out_busy;
   logic             out_buf_wr;
   ucb_hdr_t         ack_hdr;
   ucb_int_hdr_t     int_hdr;
   logic [VEC_W-1:0] ack_vec;
   logic [BUF_W-1:0] out_buf_in;
   logic [VEC_W-1:0] out_vec_in;

   ////////////////////////////////////////
   // Inbound packet and decode
   ////////////////////////////////////////

   ucb_bus_in #(.WIDTH(`UCB_IN_WIDTH)) ucb_bus_in (
      .clk      (clk),
      .rst      (rst),
      .in_vld   (in_vld),
      .in_data  (in_data),
      .stall_a1 (stall_a1),
      .stall    (stall),
      .buf_vld  (in_buf_vld),
      .in_buf   (in_buf)
   );

   // Header in the low word, write data in the high word
   assign in_hdr        = in_buf[63:0];
   assign read_pending  = in_buf_vld && (in_hdr.pkt == PKT_READ_REQ);
   assign write_pending = in_buf_vld && (in_hdr.pkt == PKT_WRITE_REQ);

   // Outstanding until its reply leaves for the serializer
   always_ff @(posedge clk) begin
      if (rst) begin
         read_outstanding <= 1'b0;
      end else if (rd_req_vld) begin
         read_outstanding <= 1'b1;
      end else if (ack_buf_rd) begin
         read_outstanding <= 1'b0;
      end
   end

   // Second read waits in the inbound buffer
   assign stall_a1   = read_pending && read_outstanding;
   assign rd_req_vld = read_pending && !read_outstanding;

   // Non double word writes vanish here
   assign wr_req_vld = write_pending && (in_hdr.size == SIZE_DWORD);

   assign req = '{thr:    in_hdr.thr,
                  buf_id: in_hdr.buf_id,
                  size:   in_hdr.size,
                  addr:   in_hdr.addr,
                  data:   in_buf[127:64]};

   ////////////////////////////////////////
   // Ack and interrupt buffers
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         ack_buf_vld <= 1'b0;
      end else if (ack_vld) begin
         ack_buf_vld <= 1'b1;
      end else if (ack_buf_rd) begin
         ack_buf_vld <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (ack_vld) begin
         ack_buf_q <= ack;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         int_buf_vld <= 1'b0;
      end else if (int_vld) begin
         int_buf_vld <= 1'b1;
      end else if (int_buf_rd) begin
         int_buf_vld <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (int_vld) begin
         int_buf_q <= int_req;
      end
   end

   // Full interrupt buffer holds off the unit
   assign int_busy = int_buf_vld;

   ////////////////////////////////////////
   // Round-robin arbitration
   ////////////////////////////////////////

   // Remembers which side won last, breaks ties the other way
   always_ff @(posedge clk) begin
      if (rst) begin
         int_last_rd <= 1'b0;
      end else if (ack_buf_rd || int_buf_rd) begin
         int_last_rd <= int_buf_rd;
      end
   end

   assign ack_buf_rd = !out_busy && ack_buf_vld && (!int_buf_vld || int_last_rd);
   assign int_buf_rd = !out_busy && int_buf_vld && (!ack_buf_vld || !int_last_rd);
   assign out_buf_wr = ack_buf_rd || int_buf_rd;

   // Outbound headers, unused fields zero
   always_comb begin
      ack_hdr        = '0;
      ack_hdr.pkt    = ack_buf_q.nack ? PKT_READ_NACK : PKT_READ_ACK;
      ack_hdr.thr    = ack_buf_q.thr;
      ack_hdr.buf_id = ack_buf_q.buf_id;
      int_hdr        = '0;
      int_hdr.pkt    = PKT_INT;
      int_hdr.thr    = int_buf_q.thr;
      int_hdr.dev    = `UCB_DEV_ID;
      int_hdr.stat   = int_buf_q.stat;
      int_hdr.vec    = int_buf_q.vec;
   end

   // Nack sends header only, ack sends 64 or 128 bits of data
   assign ack_vec = ack_buf_q.nack    ? VEC_HDR :
                    ack_buf_q.data128 ? VEC_D128 :
                                        VEC_D64;

   assign out_buf_in = ack_buf_rd ? {ack_buf_q.data, ack_hdr} :
                                    {{`UCB_REG_WIDTH{1'b0}}, int_hdr};
   assign out_vec_in = ack_buf_rd ? ack_vec : VEC_HDR;

   ucb_bus_out #(.WIDTH(OUT_W)) ucb_bus_out (
      .clk       (clk),
      .rst       (rst),
      .buf_wr    (out_buf_wr),
      .buf_in    (out_buf_in),
      .vec_in    (out_vec_in),
      .out_stall (out_stall),
      .busy      (out_busy),
      .out_vld   (out_vld),
      .out_data  (out_data)
   );

   // A new read never goes out while its predecessor's ack drains
   a_rd_vs_ack_rd: assert property (@(posedge clk) disable iff (rst)
      !(rd_req_vld && ack_buf_rd))
      else $error("ucb_noflow: read issued while ack drained");

   // Local unit respects the interrupt buffer
   a_int_vs_busy: assert property (@(posedge clk) disable iff (rst)
      !(int_vld && int_busy))
      else $error("ucb_noflow: interrupt into busy buffer");

endmodule

/* ucb_reg_unit.sv */
// UCB local register unit

`timescale 1ns/1ps

`include "ucb_cfg.svh"

module ucb_reg_unit (
   input  logic              clk,
   input  logic              rst,
   input  logic              rd_req_vld,
   input  logic              wr_req_vld,
   input  ucb_pkg::ucb_req_t req,
   input  logic              int_busy,
   output logic              ack_vld,
   output ucb_pkg::ucb_ack_t ack,
   output logic              int_vld,
   output ucb_pkg::ucb_int_t int_req
);

   import ucb_pkg::*;

   localparam int IDX_W = $clog2(`UCB_NUM_REGS);

   typedef logic [IDX_W-1:0] idx_t;

   dword_t   regs [`UCB_NUM_REGS];
   idx_t     wr_idx;
   idx_t     rd_idx;
   idx_t     rd_idx_nxt;
   logic     doorbell_wr;
   logic     rd_vld_q;
   ucb_req_t rd_q;
   ucb_ack_t ack_next;
   logic     int_pend;

   ////////////////////////////////////////
   // Register file
   ////////////////////////////////////////

   // Index from addr bits 5 to 3
   assign wr_idx = req.addr[3 +: IDX_W];

   always_ff @(posedge clk) begin
      if (wr_req_vld) begin
         regs[wr_idx] <= req.data;
      end
   end

   ////////////////////////////////////////
   // Read pipeline, two cycles to ack
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_vld_q <= 1'b0;
      end else begin
         rd_vld_q <= rd_req_vld;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_req_vld) begin
         rd_q <= req;
      end
   end

   // Upper half of a 128-bit read wraps to register 0
   assign rd_idx     = rd_q.addr[3 +: IDX_W];
   assign rd_idx_nxt = rd_idx + 1'b1;

   always_comb begin
      ack_next         = '0;
      ack_next.nack    = |rd_q.addr[39:7];
      ack_next.data128 = rd_q.addr[6];
      ack_next.thr     = rd_q.thr;
      ack_next.buf_id  = rd_q.buf_id;
      if (rd_q.addr[6]) begin
         ack_next.data = {regs[rd_idx_nxt], regs[rd_idx]};
      end else begin
         ack_next.data = {{(`UCB_REG_WIDTH-64){1'b0}}, regs[rd_idx]};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ack_vld <= 1'b0;
      end else begin
         ack_vld <= rd_vld_q;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_vld_q) begin
         ack <= ack_next;
      end
   end

   ////////////////////////////////////////
   // Doorbell interrupt
   ////////////////////////////////////////

   assign doorbell_wr = wr_req_vld && (wr_idx == IDX_W'(`UCB_DOORBELL));

   // Newer doorbell wins over one still waiting
   always_ff @(posedge clk) begin
      if (rst) begin
         int_pend <= 1'b0;
      end else if (doorbell_wr) begin
         int_pend <= 1'b1;
      end else if (int_vld) begin
         int_pend <= 1'b0;
      end
   end

   // vec from data 5:0, stat from data 9:6
   always_ff @(posedge clk) begin
      if (doorbell_wr) begin
         int_req <= '{thr: req.thr, stat: req.data[9:6], vec: req.data[5:0]};
      end
   end

   // Held back while the control block's buffer is full
   assign int_vld = int_pend && !int_busy;

endmodule

/* ucb_top.sv */
// UCB subsystem top

`timescale 1ns/1ps

`include "ucb_cfg.svh"

module ucb_top (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      in_vld,
   input  logic [`UCB_IN_WIDTH-1:0]  in_data,
   input  logic                      out_stall,
   output logic                      stall,
   output logic                      out_vld,
   output logic [`UCB_OUT_WIDTH-1:0] out_data
);

   import ucb_pkg::*;

   // Control block to local unit
   logic     rd_req_vld;
   logic     wr_req_vld;
   ucb_req_t req;
   logic     ack_vld;
   ucb_ack_t ack;
   logic     int_vld;
   ucb_int_t int_req;
   logic     int_busy;

   ucb_noflow ucb_noflow (
      .clk        (clk),
      .rst        (rst),
      .in_vld     (in_vld),
      .in_data    (in_data),
      .stall      (stall),
      .rd_req_vld (rd_req_vld),
      .wr_req_vld (wr_req_vld),
      .req        (req),
      .ack_vld    (ack_vld),
      .ack        (ack),
      .int_vld    (int_vld),
      .int_req    (int_req),
      .int_busy   (int_busy),
      .out_vld    (out_vld),
      .out_data   (out_data),
      .out_stall  (out_stall)
   );

   ucb_reg_unit ucb_reg_unit (
      .clk        (clk),
      .rst        (rst),
      .rd_req_vld (rd_req_vld),
      .wr_req_vld (wr_req_vld),
      .req        (req),
      .int_busy   (int_busy),
      .ack_vld    (ack_vld),
      .ack        (ack),
      .int_vld    (int_vld),
      .int_req    (int_req)
   );

endmodule

/* ucb_tb.sv */
// UCB subsystem testbench

`timescale 1ns/1ps

`include "ucb_cfg.svh"

module ucb_tb;

   import ucb_pkg::*;

   // Reply a table entry should produce
   typedef enum logic [2:0] {R_NONE, R_ACK64, R_ACK128, R_NACK, R_INT} reply_e;

   typedef struct packed {
      logic [2:0] test;
      ucb_pkt_e   pkt;
      thr_t       thr;
      buf_t       buf_id;
      size_t      size;
      addr_t      addr;
      dword_t     data;
      reply_e     reply;
      vec_t       vec;
      stat_t      stat;
   } entry_t;

   // Expected outbound reply with data for acks only
   typedef struct packed {
      reply_e       kind;
      thr_t         thr;
      buf_t         buf_id;
      logic [127:0] data;
      vec_t         vec;
      stat_t        stat;
   } exp_t;

   logic                      clk;
   logic                      rst;
   logic                      in_vld;
   logic [`UCB_IN_WIDTH-1:0]  in_data;
   logic                      out_stall;
   logic                      stall;
   logic                      out_vld;
   logic [`UCB_OUT_WIDTH-1:0] out_data;

   entry_t       tbl [$];
   exp_t         exp_q [$];
   dword_t       ref_regs [`UCB_NUM_REGS];
   logic [191:0] rx_buf = '0;
   int           rx_cnt = 0;
   int           rx_len = 8;
   int           errors = 0;
   int           checks = 0;
   int           test_err0 = 0;
   int           cycles = 0;
   logic         stall_rand = 1'b0;
   logic         stall_now;
   integer       seed = 32'h2207;
   integer       rnd;

   ucb_top dut0 (
      .clk       (clk),
      .rst       (rst),
      .in_vld    (in_vld),
      .in_data   (in_data),
      .out_stall (out_stall),
      .stall     (stall),
      .out_vld   (out_vld),
      .out_data  (out_data)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////

   // Pattern built from the whole address plus a tag per pass
   function automatic dword_t fill_data(input addr_t a, input logic [7:0] tag);
      return {tag ^ a[39:32], a[23:0] ^ 24'h5a3c96, ~a[31:0]};
   endfunction

   function automatic void add_write(input int t, input thr_t thr, input buf_t b,
                                     input size_t s, input addr_t a, input dword_t d,
                                     input reply_e r, input vec_t v, input stat_t st);
      entry_t e;
      e = '0;
      e.test   = t[2:0];
      e.pkt    = PKT_WRITE_REQ;
      e.thr    = thr;
      e.buf_id = b;
      e.size   = s;
      e.addr   = a;
      e.data   = d;
      e.reply  = r;
      e.vec    = v;
      e.stat   = st;
      tbl.push_back(e);
   endfunction

   function automatic void add_read(input int t, input thr_t thr, input buf_t b,
                                    input addr_t a, input reply_e r);
      entry_t e;
      e = '0;
      e.test   = t[2:0];
      e.pkt    = PKT_READ_REQ;
      e.thr    = thr;
      e.buf_id = b;
      e.size   = SIZE_DWORD;
      e.addr   = a;
      e.reply  = r;
      tbl.push_back(e);
   endfunction

   function automatic void build_table();
      addr_t  a;
      dword_t d;
      // Fill every register including the doorbell at index 7
      for (int i = 0; i < 8; i++) begin
         a = 40'(i) << 3;
         d = fill_data(a, 8'h11);
         add_write(1, 5'(i + 3), 2'(i), SIZE_DWORD, a, d, (i == 7) ? R_INT : R_NONE,
                   d[5:0], d[9:6]);
      end
      for (int i = 0; i < 8; i++) begin
         add_read(1, 5'(i + 20), 2'(i + 1), 40'(i) << 3, R_ACK64);
      end
      // Bit 6 reads where the second one wraps to register 0
      add_read(2, 5'd15, 2'd0, 40'h50, R_ACK128);
      add_read(2, 5'd16, 2'd3, 40'h78, R_ACK128);
      add_read(3, 5'd13, 2'd1, 40'h10_0000_0008, R_NACK);
      add_read(3, 5'd14, 2'd2, 40'h80, R_NACK);
      // Non dword sizes leave the register unchanged
      add_write(4, 5'd11, 2'd2, 3'b010, 40'h20, 64'hdead_0000_beef_0000, R_NONE, '0, '0);
      add_read(4, 5'd12, 2'd3, 40'h20, R_ACK64);
      add_write(4, 5'd17, 2'd0, 3'b100, 40'h28, 64'h0bad_0bad_0bad_0bad, R_NONE, '0, '0);
      add_read(4, 5'd18, 2'd1, 40'h28, R_ACK64);
      // Doorbell with vec 15 and stat a followed right away by a read
      add_write(5, 5'd21, 2'd1, SIZE_DWORD, 40'h38, 64'h295, R_INT, 6'h15, 4'ha);
      add_read(5, 5'd22, 2'd2, 40'h08, R_ACK64);
      // Back to back mix under random out_stall
      add_read(6, 5'd1, 2'd0, 40'h00, R_ACK64);
      add_read(6, 5'd2, 2'd1, 40'h48, R_ACK128);
      add_read(6, 5'd3, 2'd2, 40'h10, R_ACK64);
      add_write(6, 5'd4, 2'd3, SIZE_DWORD, 40'h10, fill_data(40'h10, 8'h66), R_NONE, '0, '0);
      add_read(6, 5'd5, 2'd0, 40'h10, R_ACK64);
      add_read(6, 5'd6, 2'd1, 40'h98, R_NACK);
      add_read(6, 5'd7, 2'd2, 40'h70, R_ACK128);
      add_read(6, 5'd8, 2'd3, 40'h20, R_ACK64);
      add_read(6, 5'd9, 2'd0, 40'h28, R_ACK64);
      add_read(6, 5'd10, 2'd1, 40'h78, R_ACK128);
   endfunction

   function automatic string test_name(input int t);
      case (t)
         1:       return "write then read";
         2:       return "128-bit read";
         3:       return "nack";
         4:       return "dropped write";
         5:       return "doorbell interrupt";
         default: return "back-pressure";
      endcase
   endfunction

   ////////////////////////////////////////
   // Inbound driver and reference model
   ////////////////////////////////////////

   task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s: got %0h, expected %0h", name, got, exp);
      end
   endtask

   // Called and returns 1 ns after a rising edge
   task automatic send_packet(input logic [127:0] pkt);
      while (stall) begin
         @(posedge clk);
         #1;
      end
      for (int i = 0; i < 4; i++) begin
         in_vld  = 1'b1;
         in_data = pkt[32*i +: 32];
         @(posedge clk);
         #1;
      end
      in_vld  = 1'b0;
      in_data = '0;
   endtask

   task automatic apply_entry(input entry_t e);
      ucb_hdr_t   h;
      exp_t       x;
      logic [2:0] idx;
      logic [2:0] idx_nxt;
      h        = '0;
      h.pkt    = e.pkt;
      h.thr    = e.thr;
      h.buf_id = e.buf_id;
      h.size   = e.size;
      h.addr   = e.addr;
      idx      = e.addr[5:3];
      idx_nxt  = idx + 3'd1;
      x        = '0;
      x.kind   = e.reply;
      x.thr    = e.thr;
      x.buf_id = e.buf_id;
      x.vec    = e.vec;
      x.stat   = e.stat;
      if (e.reply == R_ACK64) begin
         x.data = {64'h0, ref_regs[idx]};
      end else if (e.reply == R_ACK128) begin
         x.data = {ref_regs[idx_nxt], ref_regs[idx]};
      end
      if (e.pkt == PKT_WRITE_REQ && e.size == SIZE_DWORD) begin
         ref_regs[idx] = e.data;
      end
      if (e.reply != R_NONE) begin
         exp_q.push_back(x);
      end
      send_packet({e.data, h});
   endtask

   // Drain all replies of a test before reporting it
   task automatic finish_test(input int t);
      while (exp_q.size() != 0) begin
         @(posedge clk);
         #1;
      end
      stall_rand = 1'b0;
      $display("test %0d %s: %0d errors", t, test_name(t), errors - test_err0);
      test_err0 = errors;
   endtask

   initial begin
      int cur;
      rst       = 1'b1;
      in_vld    = 1'b0;
      in_data   = '0;
      out_stall = 1'b0;
      build_table();
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      // Handshake outputs come out of reset low
      check("stall", stall, 1'b0);
      check("out_vld", out_vld, 1'b0);
      cur = tbl[0].test;
      for (int i = 0; i < tbl.size(); i++) begin
         if (tbl[i].test != cur) begin
            finish_test(cur);
            cur = tbl[i].test;
         end
         stall_rand = (cur == 6);
         apply_entry(tbl[i]);
      end
      finish_test(cur);
      repeat (20) @(posedge clk);
      if (rx_cnt != 0) begin
         errors++;
         $display("reply packet still incomplete at end of run");
      end
      $display("6 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   ////////////////////////////////////////
   // Outbound stall, collector, timeout
   ////////////////////////////////////////

   always @(posedge clk) begin
      rnd       = $random(seed);
      stall_now = stall_rand && rnd[0];
      #1;
      out_stall = stall_now;
   end

   task automatic check_reply(input logic [191:0] p);
      ucb_hdr_t     ah;
      ucb_int_hdr_t ih;
      exp_t         e;
      ucb_pkt_e     t;
      ah = p[63:0];
      ih = p[63:0];
      if (exp_q.size() == 0) begin
         errors++;
         $display("reply packet arrived with no reply expected");
      end else begin
         e = exp_q.pop_front();
         t = (e.kind == R_INT)  ? PKT_INT :
             (e.kind == R_NACK) ? PKT_READ_NACK : PKT_READ_ACK;
         check("pkt_type", 128'(ah.pkt), 128'(t));
         if (e.kind == R_INT) begin
            check("int_thr", ih.thr, e.thr);
            check("int_dev", ih.dev, `UCB_DEV_ID);
            check("int_stat", ih.stat, e.stat);
            check("int_vec", ih.vec, e.vec);
         end else begin
            check("ack_thr", ah.thr, e.thr);
            check("ack_buf", ah.buf_id, e.buf_id);
            if (e.kind == R_ACK64) begin
               check("ack_data", p[127:64], e.data[63:0]);
            end else if (e.kind == R_ACK128) begin
               check("ack_data", p[191:64], e.data);
            end
         end
      end
   endtask

   // Sampled mid cycle with the length fixed once the header is in
   always @(negedge clk) begin
      if (!rst && out_vld) begin
         rx_buf[8*rx_cnt +: 8] = out_data;
         rx_cnt++;
         if (rx_cnt == 8) begin
            if (rx_buf[3:0] == PKT_READ_ACK) begin
               rx_len = (exp_q.size() != 0 && exp_q[0].kind == R_ACK128) ? 24 : 16;
            end else begin
               rx_len = 8;
            end
         end
         if (rx_cnt == rx_len) begin
            check_reply(rx_buf);
            rx_cnt = 0;
            rx_buf = '0;
         end
      end
   end

   // 200 cycles per table entry
   always @(posedge clk) begin
      if (!rst) begin
         cycles++;
         if (cycles >= tbl.size() * 200) begin
            $display("timeout after %0d cycles, %0d replies missing", cycles, exp_q.size());
            $display("Errors found");
            $finish;
         end
      end
   end

endmodule

/* ucb.f */
+incdir+.
ucb_pkg.sv
ucb_bus_in.sv
ucb_bus_out.sv
ucb_noflow.sv
ucb_reg_unit.sv
ucb_top.sv
ucb_tb.sv

/* Bender.yml */
package:
  name: ucb

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ucb_pkg.sv
      - ucb_bus_in.sv
      - ucb_bus_out.sv
      - ucb_noflow.sv
      - ucb_reg_unit.sv
      - ucb_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - ucb_tb.sv
